//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_load_queue
FILELIST  ?= list.f
FLAGS     ?= --timing --assert -Wno-fatal
BUILD     ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- list.f
verilog/lq_pkg.sv
verilog/lq_ifs.sv
verilog/rr_arbiter.sv
verilog/lq_alloc.sv
verilog/sq_search.sv
verilog/lq_entry_array.sv
verilog/load_queue.sv
verif/tb_load_queue.sv

//--- verif/tb_load_queue.sv
`timescale 1ns/1ps

module tb_load_queue;
    import lq_pkg::*;

    localparam int test_cycles   = 160;
    localparam int margin_cycles = 240;
    localparam int kind_cache    = 1;
    localparam int kind_fwd      = 2;
    localparam int kind_flushed  = 3;

    logic                       clock;
    logic                       arst_n;
    logic                       except;
    logic      [lq_ways-1:0]    ld_en;
    mem_size_t [lq_ways-1:0]    ld_size;
    rob_idx_t  [lq_ways-1:0]    ld_rob_idx;
    prf_idx_t  [lq_ways-1:0]    ld_prf_idx;
    sq_idx_t   [lq_ways-1:0]    ld_sq_tail;
    logic      [lq_ways-1:0]    agu_valid;
    rob_idx_t  [lq_ways-1:0]    agu_rob_idx;
    addr_t     [lq_ways-1:0]    agu_addr;
    mem_size_t [sq_entries-1:0] sq_size;
    addr_t     [sq_entries-1:0] sq_addr;
    data_t     [sq_entries-1:0] sq_data;
    logic      [sq_entries-1:0] sq_addr_valid;
    logic      [sq_entries-1:0] sq_data_valid;
    sq_idx_t                    sq_head;
    logic                       dc_hit;
    data_t                      dc_data;
    lq_count_t                  lq_free_count;
    logic                       rd_en;
    logic [tag_bits-1:0]        rd_tag;
    logic [set_bits-1:0]        rd_set;
    logic [offset_bits-1:0]     rd_offset;
    mem_size_t                  rd_size;
    logic [lq_entries-1:0]      rd_gnt;
    logic                       cdb_valid;
    data_t                      cdb_data;
    prf_idx_t                   cdb_prf_idx;
    rob_idx_t                   cdb_rob_idx;
    addr_t                      rd_addr;

    // expected loads by rob index
    // a load is live while the two generation counts differ
    int        exp_gen  [rob_entries];
    int        got_gen  [rob_entries] = '{default: 0};
    int        exp_kind [rob_entries];
    data_t     exp_data [rob_entries];
    prf_idx_t  exp_prf  [rob_entries];
    addr_t     exp_addr [rob_entries];
    mem_size_t exp_size [rob_entries];

    rob_idx_t  st_rob  [lq_ways];
    prf_idx_t  st_prf  [lq_ways];
    addr_t     st_addr [lq_ways];
    mem_size_t st_size [lq_ways];
    rob_idx_t  rob_next;
    rob_idx_t  first_rob;
    data_t     fwd_word;
    logic      idle;
    logic      fwd_guard;
    logic      stall_guard;
    logic      miss_on;
    addr_t     miss_addr;
    int        miss_reqs    = 0;
    int        check_errors = 0;
    int        flow_errors;

    initial clock = 1'b0;
    always #50 clock = ~clock;

    load_queue load_queue_inst (
        .clock         (clock),
        .arst_n        (arst_n),
        .except        (except),
        .ld_en         (ld_en),
        .ld_size       (ld_size),
        .ld_rob_idx    (ld_rob_idx),
        .ld_prf_idx    (ld_prf_idx),
        .ld_sq_tail    (ld_sq_tail),
        .agu_valid     (agu_valid),
        .agu_rob_idx   (agu_rob_idx),
        .agu_addr      (agu_addr),
        .sq_size       (sq_size),
        .sq_addr       (sq_addr),
        .sq_data       (sq_data),
        .sq_addr_valid (sq_addr_valid),
        .sq_data_valid (sq_data_valid),
        .sq_head       (sq_head),
        .dc_hit        (dc_hit),
        .dc_data       (dc_data),
        .lq_free_count (lq_free_count),
        .rd_en         (rd_en),
        .rd_tag        (rd_tag),
        .rd_set        (rd_set),
        .rd_offset     (rd_offset),
        .rd_size       (rd_size),
        .rd_gnt        (rd_gnt),
        .cdb_valid     (cdb_valid),
        .cdb_data      (cdb_data),
        .cdb_prf_idx   (cdb_prf_idx),
        .cdb_rob_idx   (cdb_rob_idx)
    );

    assign rd_addr = {rd_tag, rd_set, rd_offset};

    function automatic data_t cache_word(addr_t a);
        return {a, ~a} ^ 32'h5a5a_0f0f;
    endfunction

    // same-cycle cache that misses only on the chosen address
    always_comb begin
        dc_hit  = rd_en && !(miss_on && rd_addr == miss_addr);
        dc_data = cache_word(rd_addr);
    end

    function automatic logic read_expected(addr_t a, mem_size_t s);
        logic hit;
        hit = 1'b0;
        for (int r = 0; r < rob_entries; r++) begin
            if (exp_gen[r] != got_gen[r] && exp_kind[r] == kind_cache &&
                exp_addr[r] == a && exp_size[r] == s) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic logic all_done();
        logic ok;
        ok = 1'b1;
        for (int r = 0; r < rob_entries; r++) begin
            if (exp_gen[r] != got_gen[r] && exp_kind[r] != kind_flushed) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // read and bus monitor
    always @(posedge clock) begin
        if (arst_n && rd_en) begin
            assert (read_expected(rd_addr, rd_size)) else begin
                check_errors++;
                $display("[FAIL] rd_addr 0x%h rd_size 0x%h matches no waiting load",
                         rd_addr, rd_size);
            end
            if (miss_on && rd_addr == miss_addr) begin
                miss_reqs++;
            end
        end
        if (arst_n && cdb_valid) begin
            assert (exp_gen[cdb_rob_idx] != got_gen[cdb_rob_idx] &&
                    exp_kind[cdb_rob_idx] != kind_flushed) else begin
                check_errors++;
                $display("broadcast for rob index 0x%h which has no live load", cdb_rob_idx);
            end
            assert (cdb_data == exp_data[cdb_rob_idx]) else begin
                check_errors++;
                $display("[FAIL] cdb_data got 0x%h expected 0x%h",
                         cdb_data, exp_data[cdb_rob_idx]);
            end
            assert (cdb_prf_idx == exp_prf[cdb_rob_idx]) else begin
                check_errors++;
                $display("[FAIL] cdb_prf_idx got 0x%h expected 0x%h",
                         cdb_prf_idx, exp_prf[cdb_rob_idx]);
            end
            got_gen[cdb_rob_idx] = exp_gen[cdb_rob_idx];
        end
    end

    assert property (@(posedge clock) disable iff (!arst_n) idle |-> !rd_en && !cdb_valid)
        else begin
            check_errors++;
            $display("[FAIL] rd_en 0x%h cdb_valid 0x%h with no loads dispatched",
                     $sampled(rd_en), $sampled(cdb_valid));
        end

    assert property (@(posedge clock) disable iff (!arst_n)
                     idle |-> lq_free_count == lq_count_t'(lq_entries))
        else begin
            check_errors++;
            $display("[FAIL] lq_free_count got 0x%h expected 0x%h",
                     $sampled(lq_free_count), lq_entries);
        end

    // below one full group the count must read zero
    assert property (@(posedge clock) disable iff (!arst_n)
                     lq_free_count != '0 |-> lq_free_count >= lq_count_t'(lq_ways))
        else begin
            check_errors++;
            $display("[FAIL] lq_free_count 0x%h is nonzero but below 0x4",
                     $sampled(lq_free_count));
        end

    assert property (@(posedge clock) disable iff (!arst_n) fwd_guard |-> rd_gnt == '0)
        else begin
            check_errors++;
            $display("[FAIL] rd_gnt 0x%h for a forwarded load", $sampled(rd_gnt));
        end

    assert property (@(posedge clock) disable iff (!arst_n) stall_guard |-> !rd_en)
        else begin
            check_errors++;
            $display("[FAIL] rd_en 0x%h for a load behind a hidden store address",
                     $sampled(rd_en));
        end

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic expect_count(input lq_count_t exp, input string what);
        assert (lq_free_count == exp) else begin
            flow_errors++;
            $display("[FAIL] lq_free_count got 0x%h expected 0x%h (%s)",
                     lq_free_count, exp, what);
        end
    endtask

    task automatic sq_clear();
        sq_size       = '0;
        sq_addr       = '0;
        sq_data       = '0;
        sq_addr_valid = '0;
        sq_data_valid = '0;
        sq_head       = '0;
    endtask

    task automatic stage_loads(input int n);
        for (int w = 0; w < n; w++) begin
            st_rob[w]  = rob_next;
            rob_next   = rob_next + 1'b1;
            st_prf[w]  = prf_idx_t'($urandom);
            st_addr[w] = addr_t'($urandom);
            st_size[w] = mem_size_t'($urandom_range(3, 0));
        end
    endtask

    task automatic issue_loads(input int n, input int kind, input data_t fwd,
                               input sq_idx_t tail);
        rob_idx_t r;
        while (lq_free_count < lq_count_t'(n)) begin
            next_cycle();
        end
        idle = 1'b0;
        for (int w = 0; w < n; w++) begin
            r             = st_rob[w];
            ld_en[w]      = 1'b1;
            ld_size[w]    = st_size[w];
            ld_rob_idx[w] = r;
            ld_prf_idx[w] = st_prf[w];
            ld_sq_tail[w] = tail;
            exp_kind[r]   = kind;
            exp_addr[r]   = st_addr[w];
            exp_size[r]   = st_size[w];
            exp_prf[r]    = st_prf[w];
            exp_data[r]   = (kind == kind_fwd) ? fwd : cache_word(st_addr[w]);
            exp_gen[r]    = exp_gen[r] + 1;
        end
        next_cycle();
        ld_en = '0;
    endtask

    // consecutive rob indices with addresses taken from the expectations
    task automatic broadcast_addrs(input rob_idx_t first, input int n);
        for (int w = 0; w < n; w++) begin
            agu_valid[w]   = 1'b1;
            agu_rob_idx[w] = first + rob_idx_t'(w);
            agu_addr[w]    = exp_addr[first + rob_idx_t'(w)];
        end
        next_cycle();
        agu_valid = '0;
    endtask

    task automatic wait_all_done();
        while (!all_done()) begin
            next_cycle();
        end
    endtask

    initial begin
        void'($urandom(32'h9507_dd6f));
        arst_n      = 1'b0;
        except      = 1'b0;
        ld_en       = '0;
        ld_size     = '0;
        ld_rob_idx  = '0;
        ld_prf_idx  = '0;
        ld_sq_tail  = '0;
        agu_valid   = '0;
        agu_rob_idx = '0;
        agu_addr    = '0;
        sq_clear();
        idle        = 1'b1;
        fwd_guard   = 1'b0;
        stall_guard = 1'b0;
        miss_on     = 1'b0;
        miss_addr   = '0;
        flow_errors = 0;
        rob_next    = rob_idx_t'($urandom);
        for (int r = 0; r < rob_entries; r++) begin
            exp_gen[r]  = 0;
            exp_kind[r] = 0;
        end
        repeat (2) @(posedge clock);
        #1;
        arst_n = 1'b1;
        repeat (4) next_cycle();
        expect_count(lq_count_t'(lq_entries), "after reset");

        // four loads without stores where one address misses first
        stage_loads(4);
        miss_addr = st_addr[1];
        miss_on   = 1'b1;
        issue_loads(4, kind_cache, '0, '0);
        broadcast_addrs(st_rob[0], 4);
        while (miss_reqs < 2) begin
            next_cycle();
        end
        miss_on = 1'b0;
        wait_all_done();

        // the younger of two older stores to one address forwards
        sq_clear();
        stage_loads(1);
        st_size[0]       = size_word;
        fwd_word         = data_t'($urandom);
        sq_addr[0]       = st_addr[0];
        sq_size[0]       = size_word;
        sq_data[0]       = ~fwd_word;
        sq_addr[1]       = st_addr[0];
        sq_size[1]       = size_word;
        sq_data[1]       = fwd_word;
        sq_addr_valid    = 16'h0003;
        sq_data_valid    = 16'h0003;
        fwd_guard        = 1'b1;
        issue_loads(1, kind_fwd, fwd_word, sq_idx_t'(2));
        broadcast_addrs(st_rob[0], 1);
        wait_all_done();
        fwd_guard = 1'b0;

        // older store with a hidden address holds the load back
        sq_clear();
        stage_loads(1);
        stall_guard = 1'b1;
        issue_loads(1, kind_cache, '0, sq_idx_t'(1));
        broadcast_addrs(st_rob[0], 1);
        repeat (8) next_cycle();
        sq_addr[0]       = st_addr[0] ^ addr_t'(16'h0100);
        sq_size[0]       = st_size[0];
        sq_addr_valid[0] = 1'b1;
        stall_guard      = 1'b0;
        wait_all_done();

        // fill the queue and then drain it
        sq_clear();
        first_rob = rob_next;
        for (int g = 0; g < 4; g++) begin
            stage_loads(4);
            issue_loads(4, kind_cache, '0, '0);
            if (g == 2) begin
                expect_count(lq_count_t'(4), "three groups held");
            end
        end
        expect_count('0, "sixteen held");
        for (int g = 0; g < 4; g++) begin
            broadcast_addrs(first_rob + rob_idx_t'(g * 4), 4);
        end
        wait_all_done();
        expect_count(lq_count_t'(lq_entries), "all broadcast");

        // flush with addresses captured but nothing read yet
        stage_loads(4);
        issue_loads(4, kind_cache, '0, '0);
        broadcast_addrs(st_rob[0], 4);
        except = 1'b1;
        for (int w = 0; w < 4; w++) begin
            exp_kind[st_rob[w]] = kind_flushed;
        end
        next_cycle();
        except = 1'b0;
        idle   = 1'b1;
        expect_count(lq_count_t'(lq_entries), "after flush");
        repeat (10) next_cycle();

        $display("errors: %0d from assertions, %0d from flow checks",
                 check_errors, flow_errors);
        if (check_errors == 0 && flow_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (test_cycles + margin_cycles) @(posedge clock);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- verilog/load_queue.sv
`timescale 1ns/1ps

module load_queue (
    input  logic                                        clock,
    input  logic                                        arst_n,
    input  logic                                        except,
    input  logic [lq_pkg::lq_ways-1:0]                  ld_en,
    input  lq_pkg::mem_size_t [lq_pkg::lq_ways-1:0]     ld_size,
    input  lq_pkg::rob_idx_t  [lq_pkg::lq_ways-1:0]     ld_rob_idx,
    input  lq_pkg::prf_idx_t  [lq_pkg::lq_ways-1:0]     ld_prf_idx,
    input  lq_pkg::sq_idx_t   [lq_pkg::lq_ways-1:0]     ld_sq_tail,
    input  logic [lq_pkg::lq_ways-1:0]                  agu_valid,
    input  lq_pkg::rob_idx_t  [lq_pkg::lq_ways-1:0]     agu_rob_idx,
    input  lq_pkg::addr_t     [lq_pkg::lq_ways-1:0]     agu_addr,
    input  lq_pkg::mem_size_t [lq_pkg::sq_entries-1:0] sq_size,
    input  lq_pkg::addr_t     [lq_pkg::sq_entries-1:0] sq_addr,
    input  lq_pkg::data_t     [lq_pkg::sq_entries-1:0] sq_data,
    input  logic [lq_pkg::sq_entries-1:0]               sq_addr_valid,
    input  logic [lq_pkg::sq_entries-1:0]               sq_data_valid,
    input  lq_pkg::sq_idx_t                             sq_head,
    input  logic                                        dc_hit,
    input  lq_pkg::data_t                               dc_data,
    output lq_pkg::lq_count_t                           lq_free_count,
    output logic                                        rd_en,
    output logic [lq_pkg::tag_bits-1:0]                 rd_tag,
    output logic [lq_pkg::set_bits-1:0]                 rd_set,
    output logic [lq_pkg::offset_bits-1:0]              rd_offset,
    output lq_pkg::mem_size_t                           rd_size,
    output logic [lq_pkg::lq_entries-1:0]               rd_gnt,
    output logic                                        cdb_valid,
    output lq_pkg::data_t                               cdb_data,
    output lq_pkg::prf_idx_t                            cdb_prf_idx,
    output lq_pkg::rob_idx_t                            cdb_rob_idx
);
    import lq_pkg::*;

    logic      [lq_entries-1:0] free_mask;
    logic      [lq_entries-1:0] alloc_mask;
    mem_size_t [lq_entries-1:0] alloc_size;
    rob_idx_t  [lq_entries-1:0] alloc_rob_idx;
    prf_idx_t  [lq_entries-1:0] alloc_prf_idx;
    sq_idx_t   [lq_entries-1:0] alloc_sq_tail;
    logic      [lq_entries-1:0] done_mask;
    logic      [lq_entries-1:0] cache_req;
    logic      [lq_entries-1:0] cdb_gnt;

    sq_snoop_if sq ();
    ld_probe_if probe ();

    assign sq.size       = sq_size;
    assign sq.addr       = sq_addr;
    assign sq.data       = sq_data;
    assign sq.addr_valid = sq_addr_valid;
    assign sq.data_valid = sq_data_valid;
    assign sq.head       = sq_head;

    lq_alloc lq_alloc_inst (
        .free_mask     (free_mask),
        .ld_en         (ld_en),
        .ld_size       (ld_size),
        .ld_rob_idx    (ld_rob_idx),
        .ld_prf_idx    (ld_prf_idx),
        .ld_sq_tail    (ld_sq_tail),
        .alloc_mask    (alloc_mask),
        .alloc_size    (alloc_size),
        .alloc_rob_idx (alloc_rob_idx),
        .alloc_prf_idx (alloc_prf_idx),
        .alloc_sq_tail (alloc_sq_tail)
    );

    lq_entry_array lq_entry_array_inst (
        .clock         (clock),
        .arst_n        (arst_n),
        .except        (except),
        .agu_valid     (agu_valid),
        .agu_rob_idx   (agu_rob_idx),
        .agu_addr      (agu_addr),
        .alloc_mask    (alloc_mask),
        .alloc_size    (alloc_size),
        .alloc_rob_idx (alloc_rob_idx),
        .alloc_prf_idx (alloc_prf_idx),
        .alloc_sq_tail (alloc_sq_tail),
        .cache_gnt     (rd_gnt),
        .dc_hit        (dc_hit),
        .dc_data       (dc_data),
        .cdb_gnt       (cdb_gnt),
        .probe         (probe),
        .free_mask     (free_mask),
        .lq_free_count (lq_free_count),
        .rd_tag        (rd_tag),
        .rd_set        (rd_set),
        .rd_offset     (rd_offset),
        .rd_size       (rd_size),
        .cdb_data      (cdb_data),
        .cdb_prf_idx   (cdb_prf_idx),
        .cdb_rob_idx   (cdb_rob_idx),
        .done_mask     (done_mask)
    );

    sq_search sq_search_inst (
        .clock  (clock),
        .arst_n (arst_n),
        .except (except),
        .sq     (sq),
        .probe  (probe)
    );

    // ready mask lags a cycle, so a load that just finished is held off
    assign cache_req = probe.ready_mask & ~done_mask;

    rr_arbiter cache_arb_inst (
        .clock  (clock),
        .arst_n (arst_n),
        .req    (cache_req),
        .gnt    (rd_gnt)
    );

    rr_arbiter cdb_arb_inst (
        .clock  (clock),
        .arst_n (arst_n),
        .req    (done_mask),
        .gnt    (cdb_gnt)
    );

    assign rd_en     = |rd_gnt;
    assign cdb_valid = |cdb_gnt;

endmodule

//--- verilog/lq_alloc.sv
`timescale 1ns/1ps

module lq_alloc (
    input  logic [lq_pkg::lq_entries-1:0]                    free_mask,
    input  logic [lq_pkg::lq_ways-1:0]                       ld_en,
    input  lq_pkg::mem_size_t [lq_pkg::lq_ways-1:0]          ld_size,
    input  lq_pkg::rob_idx_t  [lq_pkg::lq_ways-1:0]          ld_rob_idx,
    input  lq_pkg::prf_idx_t  [lq_pkg::lq_ways-1:0]          ld_prf_idx,
    input  lq_pkg::sq_idx_t   [lq_pkg::lq_ways-1:0]          ld_sq_tail,
    output logic [lq_pkg::lq_entries-1:0]                    alloc_mask,
    output lq_pkg::mem_size_t [lq_pkg::lq_entries-1:0]       alloc_size,
    output lq_pkg::rob_idx_t  [lq_pkg::lq_entries-1:0]       alloc_rob_idx,
    output lq_pkg::prf_idx_t  [lq_pkg::lq_entries-1:0]       alloc_prf_idx,
    output lq_pkg::sq_idx_t   [lq_pkg::lq_entries-1:0]       alloc_sq_tail
);
    import lq_pkg::*;

    logic [lq_entries-1:0] avail;
    logic [lq_entries-1:0] pick;

    always_comb begin
        avail         = free_mask;
        pick          = '0;
        alloc_mask    = '0;
        alloc_size    = '0;
        alloc_rob_idx = '0;
        alloc_prf_idx = '0;
        alloc_sq_tail = '0;
        for (int w = 0; w < lq_ways; w++) begin
            pick = '0;
            if (ld_en[w]) begin
                if (w % 2 == 0) begin
                    // even lanes take the lowest free entry
                    for (int i = lq_entries - 1; i >= 0; i--) begin
                        if (avail[i]) begin
                            pick    = '0;
                            pick[i] = 1'b1;
                        end
                    end
                end else begin
                    // odd lanes take the highest
                    for (int i = 0; i < lq_entries; i++) begin
                        if (avail[i]) begin
                            pick    = '0;
                            pick[i] = 1'b1;
                        end
                    end
                end
            end
            avail      = avail & ~pick;
            alloc_mask = alloc_mask | pick;
            for (int i = 0; i < lq_entries; i++) begin
                if (pick[i]) begin
                    alloc_size[i]    = ld_size[w];
                    alloc_rob_idx[i] = ld_rob_idx[w];
                    alloc_prf_idx[i] = ld_prf_idx[w];
                    alloc_sq_tail[i] = ld_sq_tail[w];
                end
            end
        end
    end

endmodule

//--- verilog/lq_entry_array.sv
`timescale 1ns/1ps

module lq_entry_array (
    input  logic                                        clock,
    input  logic                                        arst_n,
    input  logic                                        except,
    input  logic [lq_pkg::lq_ways-1:0]                  agu_valid,
    input  lq_pkg::rob_idx_t  [lq_pkg::lq_ways-1:0]     agu_rob_idx,
    input  lq_pkg::addr_t     [lq_pkg::lq_ways-1:0]     agu_addr,
    input  logic [lq_pkg::lq_entries-1:0]               alloc_mask,
    input  lq_pkg::mem_size_t [lq_pkg::lq_entries-1:0] alloc_size,
    input  lq_pkg::rob_idx_t  [lq_pkg::lq_entries-1:0] alloc_rob_idx,
    input  lq_pkg::prf_idx_t  [lq_pkg::lq_entries-1:0] alloc_prf_idx,
    input  lq_pkg::sq_idx_t   [lq_pkg::lq_entries-1:0] alloc_sq_tail,
    input  logic [lq_pkg::lq_entries-1:0]               cache_gnt,
    input  logic                                        dc_hit,
    input  lq_pkg::data_t                               dc_data,
    input  logic [lq_pkg::lq_entries-1:0]               cdb_gnt,
    ld_probe_if.owner                                   probe,
    output logic [lq_pkg::lq_entries-1:0]               free_mask,
    output lq_pkg::lq_count_t                           lq_free_count,
    output logic [lq_pkg::tag_bits-1:0]                 rd_tag,
    output logic [lq_pkg::set_bits-1:0]                 rd_set,
    output logic [lq_pkg::offset_bits-1:0]              rd_offset,
    output lq_pkg::mem_size_t                           rd_size,
    output lq_pkg::data_t                               cdb_data,
    output lq_pkg::prf_idx_t                            cdb_prf_idx,
    output lq_pkg::rob_idx_t                            cdb_rob_idx,
    output logic [lq_pkg::lq_entries-1:0]               done_mask
);
    import lq_pkg::*;

    logic      [lq_entries-1:0] valid_r;
    logic      [lq_entries-1:0] addr_ready_r;
    logic      [lq_entries-1:0] done_r;
    addr_t     [lq_entries-1:0] addr_r;
    mem_size_t [lq_entries-1:0] size_r;
    rob_idx_t  [lq_entries-1:0] rob_r;
    prf_idx_t  [lq_entries-1:0] prf_r;
    sq_idx_t   [lq_entries-1:0] tail_r;
    data_t     [lq_entries-1:0] data_r;
    logic      [lq_entries-1:0] agu_hit;
    addr_t     [lq_entries-1:0] agu_sel;
    logic      [lq_entries-1:0] fill;
    data_t     [lq_entries-1:0] fill_data;
    logic      [lq_entries-1:0] free_next;
    lq_count_t                  free_cnt;
    addr_t                      rd_addr;

    // address capture by rob index, only while still waiting
    always_comb begin
        agu_hit = '0;
        agu_sel = '0;
        for (int i = 0; i < lq_entries; i++) begin
            for (int w = 0; w < lq_ways; w++) begin
                if (valid_r[i] && !addr_ready_r[i] && agu_valid[w] &&
                    agu_rob_idx[w] == rob_r[i]) begin
                    agu_hit[i] = 1'b1;
                    agu_sel[i] = agu_addr[w];
                end
            end
        end
    end

    // forwarded data wins over a cache hit
    always_comb begin
        for (int i = 0; i < lq_entries; i++) begin
            fill[i]      = probe.fwd_mask[i] || (cache_gnt[i] && dc_hit);
            fill_data[i] = probe.fwd_mask[i] ? probe.fwd_data[i] : dc_data;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_r      <= '0;
            addr_ready_r <= '0;
            done_r       <= '0;
        end else if (except) begin
            valid_r      <= '0;
            addr_ready_r <= '0;
            done_r       <= '0;
        end else begin
            valid_r      <= (valid_r & ~cdb_gnt) | alloc_mask;
            addr_ready_r <= (addr_ready_r | agu_hit) & ~cdb_gnt & ~alloc_mask;
            done_r       <= (done_r | fill) & ~cdb_gnt & ~alloc_mask;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < lq_entries; i++) begin
            if (alloc_mask[i]) begin
                size_r[i] <= alloc_size[i];
                rob_r[i]  <= alloc_rob_idx[i];
                prf_r[i]  <= alloc_prf_idx[i];
                tail_r[i] <= alloc_sq_tail[i];
            end
            if (agu_hit[i]) begin
                addr_r[i] <= agu_sel[i];
            end
            if (fill[i]) begin
                data_r[i] <= fill_data[i];
            end
        end
    end

    // free count seen by dispatch, zero below one full group
    always_comb begin
        free_next = except ? '1 : ((~valid_r) | cdb_gnt) & ~alloc_mask;
        free_cnt  = '0;
        for (int i = 0; i < lq_entries; i++) begin
            free_cnt = free_cnt + lq_count_t'(free_next[i]);
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            lq_free_count <= lq_count_t'(lq_entries);
        end else begin
            lq_free_count <= (free_cnt < lq_ways) ? '0 : free_cnt;
        end
    end

    // one-hot grants select the read and bus fields
    always_comb begin
        rd_addr     = '0;
        rd_size     = '0;
        cdb_data    = '0;
        cdb_prf_idx = '0;
        cdb_rob_idx = '0;
        for (int i = 0; i < lq_entries; i++) begin
            if (cache_gnt[i]) begin
                rd_addr = addr_r[i];
                rd_size = size_r[i];
            end
            if (cdb_gnt[i]) begin
                cdb_data    = data_r[i];
                cdb_prf_idx = prf_r[i];
                cdb_rob_idx = rob_r[i];
            end
        end
    end

    assign {rd_tag, rd_set, rd_offset} = rd_addr;
    assign free_mask = ~valid_r;
    assign done_mask = done_r;

    // finished entries drop out of the search
    assign probe.occupied   = valid_r & ~done_r;
    assign probe.addr_ready = addr_ready_r;
    assign probe.addr       = addr_r;
    assign probe.size       = size_r;
    assign probe.sq_tail    = tail_r;

endmodule

//--- verilog/lq_ifs.sv
`timescale 1ns/1ps

// store queue contents as seen by the load search
interface sq_snoop_if;
    import lq_pkg::*;

    mem_size_t [sq_entries-1:0] size;
    addr_t     [sq_entries-1:0] addr;
    data_t     [sq_entries-1:0] data;
    logic      [sq_entries-1:0] addr_valid;
    logic      [sq_entries-1:0] data_valid;
    sq_idx_t                    head;

    modport feed   (output size, addr, data, addr_valid, data_valid, head);
    modport search (input  size, addr, data, addr_valid, data_valid, head);
endinterface

// per-entry load state out, search results back
interface ld_probe_if;
    import lq_pkg::*;

    logic      [lq_entries-1:0] occupied;
    logic      [lq_entries-1:0] addr_ready;
    addr_t     [lq_entries-1:0] addr;
    mem_size_t [lq_entries-1:0] size;
    sq_idx_t   [lq_entries-1:0] sq_tail;
    logic      [lq_entries-1:0] fwd_mask;
    data_t     [lq_entries-1:0] fwd_data;
    logic      [lq_entries-1:0] ready_mask;

    modport owner (
        output occupied, addr_ready, addr, size, sq_tail,
        input  fwd_mask, fwd_data, ready_mask
    );
    modport search (
        input  occupied, addr_ready, addr, size, sq_tail,
        output fwd_mask, fwd_data, ready_mask
    );
endinterface

//--- verilog/lq_pkg.sv
package lq_pkg;

    // lanes and queue depths
    localparam int lq_ways     = 4;
    localparam int lq_entries  = 16;
    localparam int sq_entries  = 16;
    localparam int rob_entries = 32;
    localparam int prf_entries = 64;

    // data cache address split, tag above set above offset
    localparam int tag_bits    = 8;
    localparam int set_bits    = 5;
    localparam int offset_bits = 3;

    typedef logic [$clog2(rob_entries)-1:0] rob_idx_t;
    typedef logic [$clog2(prf_entries)-1:0] prf_idx_t;
    typedef logic [$clog2(lq_entries)-1:0]  lq_idx_t;
    typedef logic [$clog2(sq_entries)-1:0]  sq_idx_t;

    // one extra bit so a full queue reads 16
    typedef logic [$clog2(lq_entries):0]    lq_count_t;

    typedef logic [tag_bits+set_bits+offset_bits-1:0] addr_t;
    typedef logic [31:0] data_t;

    // access size
    typedef logic [1:0] mem_size_t;

    localparam mem_size_t size_byte   = 2'd0;
    localparam mem_size_t size_half   = 2'd1;
    localparam mem_size_t size_word   = 2'd2;
    localparam mem_size_t size_double = 2'd3;

endpackage

//--- verilog/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic [lq_pkg::lq_entries-1:0] req,
    output logic [lq_pkg::lq_entries-1:0] gnt
);
    import lq_pkg::*;

    lq_idx_t ptr;
    lq_idx_t win;
    lq_idx_t idx;

    // walk down so the request nearest the pointer is kept
    always_comb begin
        gnt = '0;
        win = ptr;
        idx = ptr;
        for (int k = lq_entries - 1; k >= 0; k--) begin
            idx = ptr + lq_idx_t'(k);
            if (req[idx]) begin
                gnt = '0;
                gnt[idx] = 1'b1;
                win = idx;
            end
        end
    end

    // next search starts just past the winner
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
        end else if (|req) begin
            ptr <= win + 1'b1;
        end
    end

endmodule

//--- verilog/sq_search.sv
`timescale 1ns/1ps

module sq_search (
    input  logic       clock,
    input  logic       arst_n,
    input  logic       except,
    sq_snoop_if.search sq,
    ld_probe_if.search probe
);
    import lq_pkg::*;

    localparam int addr_bits = $bits(addr_t);

    logic [lq_entries-1:0] ready_d;
    logic [sq_entries-1:0] older;
    logic [sq_entries-1:0] cand;
    sq_idx_t               tail;
    sq_idx_t               j;
    sq_idx_t               pick;
    logic                  found;
    addr_t                 ld_addr;

    always_comb begin
        ready_d        = '0;
        probe.fwd_mask = '0;
        probe.fwd_data = '0;
        older          = '0;
        cand           = '0;
        tail           = '0;
        j              = '0;
        pick           = '0;
        found          = 1'b0;
        ld_addr        = '0;
        for (int i = 0; i < lq_entries; i++) begin
            tail    = probe.sq_tail[i];
            ld_addr = probe.addr[i];

            // stores from head up to the snapshot are older
            for (int s = 0; s < sq_entries; s++) begin
                if (sq.head <= tail) begin
                    older[s] = (s >= sq.head) && (s < tail);
                end else begin
                    older[s] = (s >= sq.head) || (s < tail);
                end
                // an unknown address may alias, so it counts too
                cand[s] = older[s] && (!sq.addr_valid[s] ||
                          sq.addr[s][addr_bits-1:offset_bits] ==
                          ld_addr[addr_bits-1:offset_bits]);
            end

            // youngest one sits just below the snapshot, scanned last
            found = 1'b0;
            pick  = '0;
            for (int k = sq_entries; k >= 1; k--) begin
                j = tail - sq_idx_t'(k);
                if (cand[j]) begin
                    found = 1'b1;
                    pick  = j;
                end
            end

            if (probe.occupied[i] && probe.addr_ready[i]) begin
                if (!found) begin
                    ready_d[i] = 1'b1;
                end else if (sq.addr_valid[pick] && sq.data_valid[pick] &&
                             sq.addr[pick] == ld_addr &&
                             sq.size[pick] == probe.size[i]) begin
                    probe.fwd_mask[i] = 1'b1;
                    probe.fwd_data[i] = sq.data[pick];
                end
                // anything else stalls
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            probe.ready_mask <= '0;
        end else if (except) begin
            probe.ready_mask <= '0;
        end else begin
            probe.ready_mask <= ready_d;
        end
    end

endmodule
